// ==== src/f2_bus_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// 68000 bus widths and main CPU address map
////////////////////////////////////////////////////////////

package f2_bus_pkg;

    localparam int ADDR_W = 24; // Byte address
    localparam int DATA_W = 16;

    // One CPU byte address, seen as a memory access or as an IACK cycle
    typedef union packed {
        struct packed {
            logic [7:0]        region;
            logic [ADDR_W-9:0] offset;
        } mem;
        struct packed {
            logic [ADDR_W-5:0] unused;
            logic [2:0]        level;
            logic              zero;
        } iack;
    } cpu_addr_u;

    // Regions, address bits 23..16
    localparam logic [7:0] WORKRAM_REGION = 8'h10; // 0x100000 - 0x10FFFF
    localparam logic [7:0] IOPORT_REGION  = 8'h30; // 0x300000 onward

    localparam int WORKRAM_AW = 15; // 32K words

    // Function code of an interrupt acknowledge
    localparam logic [2:0] FC_IACK = 3'b111;

    // AS sampled low to DTACK low
    localparam int DTACK_DELAY = 2;

endpackage

`default_nettype wire

// ==== src/f2_board_pkg.sv ====
`default_nettype none

package f2_board_pkg;

    // Autovectored interrupt levels
    localparam logic [2:0] IRQ_VBL_LEVEL = 3'd5;
    localparam logic [2:0] IRQ_DMA_LEVEL = 3'd6;

    ////////////////////////////////////////////////////////////
    // Word offsets inside the I/O region
    ////////////////////////////////////////////////////////////
    localparam logic [2:0] PORT_DSWA = 3'd0;
    localparam logic [2:0] PORT_DSWB = 3'd1;
    localparam logic [2:0] PORT_P1   = 3'd2;
    localparam logic [2:0] PORT_P2   = 3'd3;
    localparam logic [2:0] PORT_COIN = 3'd4;

    // CPU clock enable ratio, 172/765 of the system clock
    localparam logic [9:0] CEN_NUM_DEFAULT = 10'd172;
    localparam logic [9:0] CEN_DEN_DEFAULT = 10'd765;

endpackage

`default_nettype wire

// ==== src/cpu_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One 68000 bus cycle as seen by the address decoder and the memories
interface cpu_bus_if;

    f2_bus_pkg::cpu_addr_u           addr;
    logic [1:0]                      ds_n;  // [1] upper, [0] lower
    logic                            rw;    // High for read
    logic                            as_n;
    logic [2:0]                      fc;
    logic [f2_bus_pkg::DATA_W-1:0]   wdata;

    modport decoder (
        input addr,
        input ds_n,
        input rw,
        input as_n,
        input fc,
        input wdata
    );

    // Chip select comes separately from the decoder
    modport memory (
        input addr,
        input ds_n,
        input rw,
        input wdata
    );

endinterface

`default_nettype wire

// ==== src/cpu_bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_decoder (
    input  wire                             clk,
    input  wire                             reset,
    cpu_bus_if.decoder                      bus,
    input  wire  [f2_bus_pkg::DATA_W-1:0]   ram_q,
    input  wire  [f2_bus_pkg::DATA_W-1:0]   io_q,
    output logic                            ram_sel,
    output logic                            io_sel,
    output logic [f2_bus_pkg::DATA_W-1:0]   rdata,
    output logic                            dtack_n,
    output logic                            vpa_n,
    output logic                            iack,
    output logic [2:0]                      iack_level
);

    localparam int CNT_W = $clog2(f2_bus_pkg::DTACK_DELAY + 1);

    logic             is_iack;
    logic             in_ram;
    logic             in_io;
    logic [CNT_W-1:0] wait_cnt;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign is_iack = bus.fc == f2_bus_pkg::FC_IACK;
    assign in_ram  = bus.addr.mem.region == f2_bus_pkg::WORKRAM_REGION;
    assign in_io   = bus.addr.mem.region == f2_bus_pkg::IOPORT_REGION;

    // Chip selects only during a memory cycle
    assign ram_sel = ~bus.as_n & ~is_iack & in_ram;
    assign io_sel  = ~bus.as_n & ~is_iack & in_io;

    // Interrupt acknowledge, level comes from A3..A1
    assign vpa_n      = ~(~bus.as_n & is_iack); // Autovector
    assign iack       = ~bus.as_n & is_iack & ~bus.ds_n[0];
    assign iack_level = bus.addr.iack.level;

    // Read data, unmapped regions return zero
    always_comb begin
        if (in_ram) begin
            rdata = ram_q;
        end else if (in_io) begin
            rdata = io_q;
        end else begin
            rdata = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // DTACK timing
    ////////////////////////////////////////////////////////////

    // Counts edges since AS was first sampled low
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
            dtack_n  <= 1'b1;
        end else if (bus.as_n || is_iack) begin
            wait_cnt <= '0; // End of cycle
            dtack_n  <= 1'b1;
        end else if (wait_cnt == CNT_W'(f2_bus_pkg::DTACK_DELAY)) begin
            dtack_n  <= 1'b0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/work_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module work_ram (
    input  wire                             clk,
    cpu_bus_if.memory                       bus,
    input  wire                             sel,
    output logic [f2_bus_pkg::DATA_W-1:0]   q
);

    localparam int AW = f2_bus_pkg::WORKRAM_AW;

    logic [f2_bus_pkg::DATA_W-1:0] mem [2**AW];
    logic [AW-1:0]                 word_addr;

    assign word_addr = bus.addr.mem.offset[AW:1]; // Byte address to word

    // Lane 1 is the upper byte (UDS), lane 0 the lower (LDS)
    always_ff @(posedge clk) begin
        if (sel && !bus.rw) begin
            for (int lane = 0; lane < 2; lane++) begin
                if (!bus.ds_n[lane]) begin
                    mem[word_addr][8*lane +: 8] <= bus.wdata[8*lane +: 8];
                end
            end
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        q <= mem[word_addr];
    end

endmodule

`default_nettype wire

// ==== src/input_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_ports (
    input  wire                             clk,
    cpu_bus_if.memory                       bus,
    input  wire                             sel,
    input  wire  [9:0]                      joystick_p1,
    input  wire  [9:0]                      joystick_p2,
    input  wire  [1:0]                      start,
    input  wire  [1:0]                      coin,
    input  wire  [7:0]                      dswa,
    input  wire  [7:0]                      dswb,
    output logic [f2_bus_pkg::DATA_W-1:0]   q
);

    logic [2:0] port_idx;
    logic [7:0] port_byte;

    assign port_idx = bus.addr.mem.offset[3:1];

    ////////////////////////////////////////////////////////////
    // Port select, all inputs active low on the board
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (port_idx)
            f2_board_pkg::PORT_DSWA: port_byte = ~dswa;
            f2_board_pkg::PORT_DSWB: port_byte = ~dswb;
            f2_board_pkg::PORT_P1: begin
                // Start, buttons 3..1, then right/left/down/up reversed
                port_byte = ~{start[0], joystick_p1[6:4], joystick_p1[0], joystick_p1[1],
                              joystick_p1[2], joystick_p1[3]};
            end
            f2_board_pkg::PORT_P2: begin
                port_byte = ~{start[1], joystick_p2[6:4], joystick_p2[0], joystick_p2[1],
                              joystick_p2[2], joystick_p2[3]};
            end
            f2_board_pkg::PORT_COIN: port_byte = ~{2'b00, start, coin, 2'b00};
            default: port_byte = 8'hff; // Nothing connected
        endcase
    end

    // Byte on both halves, CPU may read either lane
    always_ff @(posedge clk) begin
        if (sel && bus.rw) begin
            q <= {port_byte, port_byte};
        end
    end

endmodule

`default_nettype wire

// ==== src/irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
    input  wire         clk,
    input  wire         reset,
    input  wire         vblank_n,
    input  wire         dma_n,
    input  wire         iack,
    input  wire  [2:0]  iack_level,
    output logic [2:0]  ipl_n
);

    logic vbl_prev;
    logic dma_prev;
    logic vbl_fall;
    logic dma_rise;
    logic req_vbl;
    logic req_dma;
    logic clr_vbl;
    logic clr_dma;

    assign vbl_fall = vbl_prev & ~vblank_n; // Start of vblank
    assign dma_rise = ~dma_prev & dma_n;    // End of object DMA

    assign clr_vbl = iack && (iack_level == f2_board_pkg::IRQ_VBL_LEVEL);
    assign clr_dma = iack && (iack_level == f2_board_pkg::IRQ_DMA_LEVEL);

    ////////////////////////////////////////////////////////////
    // Edge detect and request latches
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_prev <= 1'b0; // No false edge out of reset
            dma_prev <= 1'b1;
            req_vbl  <= 1'b0;
            req_dma  <= 1'b0;
        end else begin
            vbl_prev <= vblank_n;
            dma_prev <= dma_n;

            if (vbl_fall) req_vbl <= 1'b1;
            if (dma_rise) req_dma <= 1'b1;

            // Acknowledge wins over a new edge
            if (clr_vbl) req_vbl <= 1'b0;
            if (clr_dma) req_dma <= 1'b0;
        end
    end

    // Highest pending level to the CPU
    always_comb begin
        if (req_dma) begin
            ipl_n = ~f2_board_pkg::IRQ_DMA_LEVEL;
        end else if (req_vbl) begin
            ipl_n = ~f2_board_pkg::IRQ_VBL_LEVEL;
        end else begin
            ipl_n = 3'b111;
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_clock_enable.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_clock_enable #(
    parameter logic [9:0] CEN_NUM = f2_board_pkg::CEN_NUM_DEFAULT,
    parameter logic [9:0] CEN_DEN = f2_board_pkg::CEN_DEN_DEFAULT
) (
    input  wire   clk,
    input  wire   reset,
    input  wire   pause,
    output logic  ce_cpu
);

    logic [9:0]  acc;
    logic [10:0] sum;
    logic [10:0] wrapped;

    // One extra bit so the sum cannot overflow
    assign sum     = {1'b0, acc} + {1'b0, CEN_NUM};
    assign wrapped = sum - {1'b0, CEN_DEN};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc    <= '0;
            ce_cpu <= 1'b0;
        end else begin
            ce_cpu <= 1'b0;
            if (!pause) begin // Paused holds the phase
                if (sum >= {1'b0, CEN_DEN}) begin
                    acc    <= wrapped[9:0];
                    ce_cpu <= 1'b1;
                end else begin
                    acc    <= sum[9:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/f2_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module f2_bus_ctrl #(
    parameter logic [9:0] CEN_NUM = f2_board_pkg::CEN_NUM_DEFAULT,
    parameter logic [9:0] CEN_DEN = f2_board_pkg::CEN_DEN_DEFAULT
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             pause,

    // 68000 bus
    input  wire  [f2_bus_pkg::ADDR_W-1:0]   cpu_addr,
    input  wire  [1:0]                      cpu_ds_n,
    input  wire                             cpu_rw,
    input  wire                             cpu_as_n,
    input  wire  [2:0]                      cpu_fc,
    input  wire  [f2_bus_pkg::DATA_W-1:0]   cpu_wdata,
    output logic [f2_bus_pkg::DATA_W-1:0]   rdata,
    output logic                            dtack_n,
    output logic                            vpa_n,
    output logic [2:0]                      ipl_n,
    output logic                            ce_cpu,

    input  wire                             vblank_n,
    input  wire                             dma_n,

    input  wire  [9:0]                      joystick_p1,
    input  wire  [9:0]                      joystick_p2,
    input  wire  [1:0]                      start,
    input  wire  [1:0]                      coin,
    input  wire  [7:0]                      dswa,
    input  wire  [7:0]                      dswb
);

    logic                          ram_sel;
    logic                          io_sel;
    logic [f2_bus_pkg::DATA_W-1:0] ram_q;
    logic [f2_bus_pkg::DATA_W-1:0] io_q;
    logic                          iack;
    logic [2:0]                    iack_level;

    cpu_bus_if bus ();

    assign bus.addr  = cpu_addr;
    assign bus.ds_n  = cpu_ds_n;
    assign bus.rw    = cpu_rw;
    assign bus.as_n  = cpu_as_n;
    assign bus.fc    = cpu_fc;
    assign bus.wdata = cpu_wdata;

    cpu_bus_decoder decoder (
        .clk,
        .reset,
        .bus        (bus.decoder),
        .ram_q,
        .io_q,
        .ram_sel,
        .io_sel,
        .rdata,
        .dtack_n,
        .vpa_n,
        .iack,
        .iack_level
    );

    work_ram ram (
        .clk,
        .bus (bus.memory),
        .sel (ram_sel),
        .q   (ram_q)
    );

    input_ports ports (
        .clk,
        .bus (bus.memory),
        .sel (io_sel),
        .joystick_p1,
        .joystick_p2,
        .start,
        .coin,
        .dswa,
        .dswb,
        .q   (io_q)
    );

    irq_ctrl irq (
        .clk,
        .reset,
        .vblank_n,
        .dma_n,
        .iack,
        .iack_level,
        .ipl_n
    );

    cpu_clock_enable #(
        .CEN_NUM (CEN_NUM),
        .CEN_DEN (CEN_DEN)
    ) cen (
        .clk,
        .reset,
        .pause,
        .ce_cpu
    );

endmodule

`default_nettype wire

// ==== include/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

////////////////////////////////////////////////////////////
// Timing, random numbers and compare
////////////////////////////////////////////////////////////

// Inputs change and outputs are read 1 ns after the edge
task automatic tick();
    @(posedge clk);
    #1;
endtask

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected, input int slack);
    logic [31:0] diff;
    checks++;
    diff = (got > expected) ? got - expected : expected - got;
    if ($isunknown(got) || diff > 32'(slack)) begin
        errors++;
        $display("Fail %s: got %h, expected %h at %0t", name, got, expected, $time);
    end
endtask

////////////////////////////////////////////////////////////
// 68000 bus cycles
////////////////////////////////////////////////////////////

task automatic bus_cycle(input logic [23:0] addr, input logic [2:0] fc, input logic rw,
                         input logic [1:0] ds_n, input logic [15:0] wdata,
                         output logic [15:0] data);
    int  waited;
    logic iack_cycle;
    waited = 0;
    iack_cycle = (fc == f2_bus_pkg::FC_IACK);
    cpu_addr = addr;
    cpu_fc = fc;
    cpu_rw = rw;
    cpu_ds_n = ds_n;
    cpu_wdata = wdata;
    cpu_as_n = 1'b0;
    tick();
    while ((iack_cycle ? vpa_n : dtack_n) !== 1'b0 && waited < ACK_TIMEOUT) begin
        tick();
        waited++;
    end
    if (waited >= ACK_TIMEOUT) begin
        errors++;
        $display("No acknowledge from the DUT for the cycle at address %h", addr);
    end
    data = rdata;
    cpu_as_n = 1'b1;
    cpu_ds_n = 2'b11;
    cpu_rw = 1'b1;
    waited = 0;
    while (dtack_n !== 1'b1 && waited < ACK_TIMEOUT) begin
        tick();
        waited++;
    end
    if (waited >= ACK_TIMEOUT) begin
        errors++;
        $display("dtack_n did not return high after the cycle at address %h", addr);
    end
endtask

task automatic cpu_write(input logic [23:0] addr, input logic [1:0] ds_n,
                         input logic [15:0] data);
    logic [15:0] unused_q;
    bus_cycle(addr, 3'b101, 1'b0, ds_n, data, unused_q);
endtask

task automatic cpu_read(input logic [23:0] addr, output logic [15:0] data);
    bus_cycle(addr, 3'b101, 1'b1, 2'b00, 16'h0000, data);
endtask

task automatic cpu_iack(input logic [2:0] level);
    logic [15:0] unused_q;
    bus_cycle({20'hfffff, level, 1'b0}, f2_bus_pkg::FC_IACK, 1'b1, 2'b00, 16'h0000, unused_q);
endtask

task automatic wait_for_ipl(input logic [2:0] expected);
    int waited;
    waited = 0;
    while (ipl_n !== expected && waited < IPL_TIMEOUT) begin
        tick();
        waited++;
    end
    check_value("ipl_n", 32'(ipl_n), 32'(expected), 0);
endtask

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// ds_n[1] is the upper byte lane
function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] wdata,
                                            input logic [1:0] ds_n);
    logic [15:0] merged;
    merged = old;
    if (!ds_n[1]) merged[15:8] = wdata[15:8];
    if (!ds_n[0]) merged[7:0] = wdata[7:0];
    return merged;
endfunction

function automatic logic [7:0] port_value(input logic [2:0] port);
    case (port)
        f2_board_pkg::PORT_DSWA: return ~dswa;
        f2_board_pkg::PORT_DSWB: return ~dswb;
        f2_board_pkg::PORT_P1: return ~{start[0], joystick_p1[6], joystick_p1[5],
            joystick_p1[4], joystick_p1[0], joystick_p1[1], joystick_p1[2], joystick_p1[3]};
        f2_board_pkg::PORT_P2: return ~{start[1], joystick_p2[6], joystick_p2[5],
            joystick_p2[4], joystick_p2[0], joystick_p2[1], joystick_p2[2], joystick_p2[3]};
        f2_board_pkg::PORT_COIN: return ~{2'b00, start, coin, 2'b00};
        default: return 8'hff;
    endcase
endfunction

function automatic int expected_pulses(input int cycles);
    return (cycles * int'(f2_board_pkg::CEN_NUM_DEFAULT)) / int'(f2_board_pkg::CEN_DEN_DEFAULT);
endfunction

`endif

// ==== tests/tb_f2_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_f2_bus_ctrl;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 8;
    localparam int ACK_TIMEOUT    = 16;
    localparam int IPL_TIMEOUT    = 8;
    localparam int RAM_WORDS      = 32; // Byte writes pick from these by 5 random bits
    localparam int BYTE_WRITES    = 32;
    localparam int PORT_ROUNDS    = 4;
    localparam int UNMAPPED_READS = 8;
    localparam int PAUSE_CYCLES   = 300;
    localparam int CEN_WINDOW     = 2000;

    // Worst case bus cycle is two full timeouts
    localparam int ACCESS_COUNT = 2 * RAM_WORDS + BYTE_WRITES + PORT_ROUNDS * 8 +
                                  UNMAPPED_READS + 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + ACCESS_COUNT * 2 * (ACK_TIMEOUT + 1) +
                                     4 * IPL_TIMEOUT + PAUSE_CYCLES + CEN_WINDOW + 200;

    logic        clk;
    logic        reset;
    logic        pause;
    logic [23:0] cpu_addr;
    logic [1:0]  cpu_ds_n;
    logic        cpu_rw;
    logic        cpu_as_n;
    logic [2:0]  cpu_fc;
    logic [15:0] cpu_wdata;
    logic [15:0] rdata;
    logic        dtack_n;
    logic        vpa_n;
    logic [2:0]  ipl_n;
    logic        ce_cpu;
    logic        vblank_n;
    logic        dma_n;
    logic [9:0]  joystick_p1;
    logic [9:0]  joystick_p2;
    logic [1:0]  start;
    logic [1:0]  coin;
    logic [7:0]  dswa;
    logic [7:0]  dswb;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'd3936;
    logic [15:0] shadow_mem [0:32767];
    logic [14:0] used_words [$];

    `include "tb_bus_tasks.svh"

    function automatic logic [23:0] ram_addr(input logic [14:0] idx);
        return {f2_bus_pkg::WORKRAM_REGION, idx, 1'b0};
    endfunction

    function automatic logic [23:0] io_addr(input logic [2:0] port);
        return {f2_bus_pkg::IOPORT_REGION, 12'h000, port, 1'b0};
    endfunction

    f2_bus_ctrl #(
        .CEN_NUM (f2_board_pkg::CEN_NUM_DEFAULT),
        .CEN_DEN (f2_board_pkg::CEN_DEN_DEFAULT)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .pause       (pause),
        .cpu_addr    (cpu_addr),
        .cpu_ds_n    (cpu_ds_n),
        .cpu_rw      (cpu_rw),
        .cpu_as_n    (cpu_as_n),
        .cpu_fc      (cpu_fc),
        .cpu_wdata   (cpu_wdata),
        .rdata       (rdata),
        .dtack_n     (dtack_n),
        .vpa_n       (vpa_n),
        .ipl_n       (ipl_n),
        .ce_cpu      (ce_cpu),
        .vblank_n    (vblank_n),
        .dma_n       (dma_n),
        .joystick_p1 (joystick_p1),
        .joystick_p2 (joystick_p2),
        .start       (start),
        .coin        (coin),
        .dswa        (dswa),
        .dswb        (dswb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the test sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin : test_sequence
        logic [31:0] rnd;
        logic [23:0] addr;
        logic [14:0] idx;
        logic [15:0] data;
        logic [1:0]  ds;
        int          pulses;

        reset = 1'b1;
        pause = 1'b0;
        cpu_addr = '0;
        cpu_ds_n = 2'b11;
        cpu_rw = 1'b1;
        cpu_as_n = 1'b1;
        cpu_fc = 3'b000;
        cpu_wdata = '0;
        vblank_n = 1'b1;
        dma_n = 1'b0;
        joystick_p1 = '0;
        joystick_p2 = '0;
        start = '0;
        coin = '0;
        dswa = '0;
        dswb = '0;
        repeat (RESET_CYCLES) tick();
        check_value("dtack_n", 32'(dtack_n), 32'd1, 0);
        check_value("vpa_n", 32'(vpa_n), 32'd1, 0);
        check_value("ipl_n", 32'(ipl_n), 32'd7, 0);
        check_value("ce_cpu", 32'(ce_cpu), 32'd0, 0);
        reset = 1'b0;

        ////////////////////////////////////////////////////////////
        // Work RAM, full words first so every read is defined
        ////////////////////////////////////////////////////////////
        for (int i = 0; i < RAM_WORDS; i++) begin
            rnd = lcg_next();
            idx = rnd[16:2];
            cpu_write(ram_addr(idx), 2'b00, rnd[31:16]);
            shadow_mem[idx] = rnd[31:16];
            used_words.push_back(idx);
        end
        for (int i = 0; i < BYTE_WRITES; i++) begin
            rnd = lcg_next();
            idx = used_words[rnd[4:0]];
            ds = (rnd[9:8] == 2'b11) ? 2'b00 : rnd[9:8]; // Word, upper or lower
            cpu_write(ram_addr(idx), ds, rnd[31:16]);
            shadow_mem[idx] = merge_lanes(shadow_mem[idx], rnd[31:16], ds);
        end
        foreach (used_words[i]) begin
            cpu_read(ram_addr(used_words[i]), data);
            check_value("rdata", 32'(data), 32'(shadow_mem[used_words[i]]), 0);
        end

        ////////////////////////////////////////////////////////////
        // Input ports, offset 5 is unconnected
        ////////////////////////////////////////////////////////////
        for (int r = 0; r < PORT_ROUNDS; r++) begin
            rnd = lcg_next();
            joystick_p1 = rnd[9:0];
            joystick_p2 = rnd[19:10];
            start = rnd[21:20];
            coin = rnd[23:22];
            dswa = rnd[31:24];
            rnd = lcg_next();
            dswb = rnd[7:0];
            for (int p = 0; p < 6; p++) begin
                cpu_read(io_addr(3'(p)), data);
                check_value("rdata", 32'(data), 32'({2{port_value(3'(p))}}), 0);
            end
            cpu_write(io_addr(f2_board_pkg::PORT_P1), 2'b00, rnd[31:16]);
            cpu_read(io_addr(f2_board_pkg::PORT_P1), data);
            check_value("rdata", 32'(data), 32'({2{port_value(f2_board_pkg::PORT_P1)}}), 0);
        end

        // Unmapped space reads zero
        for (int i = 0; i < UNMAPPED_READS; i++) begin
            rnd = lcg_next();
            addr = {rnd[23:1], 1'b0};
            if (addr[23:16] == f2_bus_pkg::WORKRAM_REGION ||
                addr[23:16] == f2_bus_pkg::IOPORT_REGION) begin
                addr[23] = 1'b1;
            end
            cpu_read(addr, data);
            check_value("rdata", 32'(data), 32'd0, 0);
        end

        ////////////////////////////////////////////////////////////
        // Interrupts
        ////////////////////////////////////////////////////////////
        vblank_n = 1'b0;
        wait_for_ipl(~f2_board_pkg::IRQ_VBL_LEVEL);
        vblank_n = 1'b1;
        dma_n = 1'b1;
        wait_for_ipl(~f2_board_pkg::IRQ_DMA_LEVEL);
        cpu_iack(f2_board_pkg::IRQ_DMA_LEVEL);
        wait_for_ipl(~f2_board_pkg::IRQ_VBL_LEVEL);
        cpu_iack(f2_board_pkg::IRQ_VBL_LEVEL);
        wait_for_ipl(3'b111);

        // Clock enable, frozen and then free running
        pause = 1'b1;
        pulses = 0;
        repeat (PAUSE_CYCLES) begin
            tick();
            if (ce_cpu) pulses++;
        end
        check_value("ce_cpu pulses while paused", 32'(pulses), 32'd0, 0);
        pause = 1'b0;
        pulses = 0;
        repeat (CEN_WINDOW) begin
            tick();
            if (ce_cpu) pulses++;
        end
        check_value("ce_cpu pulses", 32'(pulses), 32'(expected_pulses(CEN_WINDOW)), 1);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== f2_bus_ctrl.f ====
+incdir+include
src/f2_bus_pkg.sv
src/f2_board_pkg.sv
src/cpu_bus_if.sv
src/cpu_bus_decoder.sv
src/work_ram.sv
src/input_ports.sv
src/irq_ctrl.sv
src/cpu_clock_enable.sv
src/f2_bus_ctrl.sv
tests/tb_f2_bus_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bus controller testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -j 0 --top-module tb_f2_bus_ctrl \
    -f f2_bus_ctrl.f -Mdir "$BUILD_DIR" -o sim_f2_bus_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_f2_bus_ctrl" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qF 'All tests passed!' "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
